/* common/alu_pkg.sv */
`default_nettype none

package alu_pkg;

  // ****************************************
  // Widths
  // ****************************************

  // Data path width, all other widths follow from it
  localparam int word_w = 64;

  // Iteration counter for the one-bit-per-clock mul/div
  localparam int iter_w = 7;

  // Count value of the last run cycle
  localparam logic [iter_w-1:0] iter_last = iter_w'(word_w - 1);

  typedef logic [word_w-1:0]   word_t;
  typedef logic [2*word_w-1:0] dword_t;
  typedef logic [4:0]          alu_op_t;

  // ****************************************
  // Opcodes
  // ****************************************

  // Number of defined opcodes, codes at or above this pass S
  localparam int op_count = 26;

  localparam alu_op_t op_inc    = 5'd0;
  localparam alu_op_t op_dec    = 5'd1;
  localparam alu_op_t op_mul    = 5'd2;
  localparam alu_op_t op_msw    = 5'd3;
  localparam alu_op_t op_div    = 5'd4;
  localparam alu_op_t op_rem    = 5'd5;
  localparam alu_op_t op_add    = 5'd6;
  localparam alu_op_t op_sub    = 5'd7;
  localparam alu_op_t op_and    = 5'd8;
  localparam alu_op_t op_or     = 5'd9;
  localparam alu_op_t op_xor    = 5'd10;
  localparam alu_op_t op_not    = 5'd11;
  localparam alu_op_t op_neg    = 5'd12;
  localparam alu_op_t op_lshl   = 5'd13;
  localparam alu_op_t op_lshr   = 5'd14;
  localparam alu_op_t op_ashl   = 5'd15;
  localparam alu_op_t op_ashr   = 5'd16;
  localparam alu_op_t op_zeros  = 5'd17;
  localparam alu_op_t op_ones   = 5'd18;
  localparam alu_op_t op_pass_r = 5'd19;
  localparam alu_op_t op_pass_s = 5'd20;
  localparam alu_op_t op_nand   = 5'd21;
  localparam alu_op_t op_nor    = 5'd22;
  localparam alu_op_t op_xnor   = 5'd23;
  localparam alu_op_t op_ror    = 5'd24;
  localparam alu_op_t op_rol    = 5'd25;

  // ****************************************
  // State machines
  // ****************************************

  // Top level handshake controller
  typedef enum logic [1:0] {ctrl_idle, ctrl_busy, ctrl_done} ctrl_state_e;

  // Iterative mul/div, fix applies the sign correction
  typedef enum logic [1:0] {md_idle, md_run, md_fix} md_state_e;

endpackage

`default_nettype wire

/* source/alu_logic_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_logic_unit (
  input  wire alu_pkg::alu_op_t op,
  input  wire alu_pkg::word_t   r,
  input  wire alu_pkg::word_t   s,
  output alu_pkg::word_t        y,
  output logic                  c,
  output logic                  n,
  output logic                  v,
  output logic                  z
);

  // Sign bit position
  localparam int msb = alu_pkg::word_w - 1;

  always_comb begin
    // Flags not touched by an opcode stay low
    c = 1'b0;
    v = 1'b0;
    y = s;

    if (op >= alu_pkg::op_count) begin
      // Spare opcodes behave as PASS S
      y = s;
    end else begin
      case (op)
        // ****************************************
        // Arithmetic
        // ****************************************
        alu_pkg::op_inc: begin
          {c, y} = {1'b0, s} + 1'b1;
          // Positive operand wrapping to negative
          v = ~s[msb] & y[msb];
        end
        alu_pkg::op_dec: begin
          // Borrow out of zero shows up in C
          {c, y} = {1'b0, s} - 1'b1;
          v = s[msb] & ~y[msb];
        end
        alu_pkg::op_add: begin
          {c, y} = {1'b0, r} + {1'b0, s};
          // Same operand signs but result sign differs
          v = (r[msb] == s[msb]) & (y[msb] != r[msb]);
        end
        alu_pkg::op_sub: begin
          {c, y} = {1'b0, r} - {1'b0, s};
          v = (r[msb] != s[msb]) & (y[msb] != r[msb]);
        end
        alu_pkg::op_neg: begin
          y = ~s + 1'b1;
          // Only the most negative value overflows
          v = s[msb] & y[msb];
        end

        // ****************************************
        // Logic and constants
        // ****************************************
        alu_pkg::op_and:    y = r & s;
        alu_pkg::op_or:     y = r | s;
        alu_pkg::op_xor:    y = r ^ s;
        alu_pkg::op_not:    y = ~s;
        alu_pkg::op_nand:   y = ~(r & s);
        alu_pkg::op_nor:    y = ~(r | s);
        alu_pkg::op_xnor:   y = ~(r ^ s);
        alu_pkg::op_zeros:  y = '0;
        alu_pkg::op_ones:   y = '1;
        alu_pkg::op_pass_r: y = r;
        alu_pkg::op_pass_s: y = s;

        // ****************************************
        // Shifts and rotates
        // ****************************************
        alu_pkg::op_lshl: begin
          c = s[msb];
          y = {s[msb-1:0], 1'b0};
        end
        alu_pkg::op_lshr: begin
          c = s[0];
          y = {1'b0, s[msb:1]};
        end
        alu_pkg::op_ashl: begin
          // Sign bit kept, bit below it is the one dropped
          c = s[msb-1];
          y = {s[msb], s[msb-2:0], 1'b0};
          v = s[msb] ^ s[msb-1];
        end
        alu_pkg::op_ashr: begin
          c = s[0];
          y = {s[msb], s[msb:1]};
        end
        alu_pkg::op_ror: begin
          c = s[0];
          y = {s[0], s[msb:1]};
        end
        alu_pkg::op_rol: begin
          c = s[msb];
          y = {s[msb-1:0], s[msb]};
        end

        // Mul/div codes land here, the top never uses this result for them
        default: y = s;
      endcase
    end
  end

  // Sign and zero flags come straight from the result
  assign n = y[msb];
  assign z = (y == '0);

endmodule

`default_nettype wire

/* muldiv/muldiv_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module muldiv_unit (
  input  wire logic           clk,
  input  wire logic           rst_n,
  input  wire logic           start,
  input  wire logic           is_div,
  input  wire alu_pkg::word_t r,
  input  wire alu_pkg::word_t s,
  output logic                done,
  output alu_pkg::word_t      lo,
  output alu_pkg::word_t      hi,
  output logic                neg,
  output logic                zero,
  output logic                div_zero
);

  localparam int msb = alu_pkg::word_w - 1;

  alu_pkg::md_state_e           state_q;
  logic [alu_pkg::iter_w-1:0]   cnt_q;

  // Working register split in halves, plus the fixed operand
  alu_pkg::word_t               acc_hi;
  alu_pkg::word_t               acc_lo;
  alu_pkg::word_t               opnd;
  logic                         sign_q;
  logic                         div_q;
  logic                         dz_q;

  alu_pkg::word_t               r_mag;
  alu_pkg::word_t               s_mag;
  logic                         dz_start;
  logic [alu_pkg::word_w:0]     add_sum;
  alu_pkg::word_t               shl_hi;
  logic [alu_pkg::word_w:0]     diff;
  alu_pkg::dword_t              fixed;

  // Operand magnitudes, the most negative value maps onto itself as unsigned
  assign r_mag = r[msb] ? (~r + 1'b1) : r;
  assign s_mag = s[msb] ? (~s + 1'b1) : s;

  assign dz_start = is_div & (s == '0);

  // Shift-add step, multiplicand added into the high half when LSB is set
  assign add_sum = {1'b0, acc_hi} + {1'b0, (acc_lo[0] ? opnd : alu_pkg::word_t'(0))};

  // Restoring step, trial subtract of the divisor from the shifted remainder
  assign shl_hi = {acc_hi[msb-1:0], acc_lo[msb]};
  assign diff   = {1'b0, shl_hi} - {1'b0, opnd};

  // ****************************************
  // Sign fix
  // ****************************************
  always_comb begin
    fixed = {acc_hi, acc_lo};
    if (dz_q) begin
      fixed = '0;
    end else if (sign_q) begin
      if (div_q) begin
        // Quotient only, remainder keeps its magnitude
        fixed[msb:0] = ~acc_lo + 1'b1;
      end else begin
        fixed = ~{acc_hi, acc_lo} + 1'b1;
      end
    end
  end

  // ****************************************
  // Control FSM
  // ****************************************
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= alu_pkg::md_idle;
      cnt_q   <= '0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state_q)
        alu_pkg::md_idle: begin
          cnt_q <= '0;
          // Divide by zero skips straight to the fix cycle
          if (start) state_q <= dz_start ? alu_pkg::md_fix : alu_pkg::md_run;
        end
        alu_pkg::md_run: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == alu_pkg::iter_last) state_q <= alu_pkg::md_fix;
        end
        alu_pkg::md_fix: begin
          done    <= 1'b1;
          state_q <= alu_pkg::md_idle;
        end
        default: state_q <= alu_pkg::md_idle;
      endcase
    end
  end

  // Datapath, one quotient or multiplier bit per run cycle
  always_ff @(posedge clk) begin
    if (state_q == alu_pkg::md_idle && start) begin
      sign_q <= r[msb] ^ s[msb];
      div_q  <= is_div;
      dz_q   <= dz_start;
      acc_hi <= '0;
      // Dividend or multiplier sits in the low half
      acc_lo <= is_div ? r_mag : s_mag;
      opnd   <= is_div ? s_mag : r_mag;
    end else if (state_q == alu_pkg::md_run) begin
      if (div_q) begin
        if (!diff[alu_pkg::word_w]) begin
          acc_hi <= diff[msb:0];
          acc_lo <= {acc_lo[msb-1:0], 1'b1};
        end else begin
          // Negative trial, keep the shifted remainder
          acc_hi <= shl_hi;
          acc_lo <= {acc_lo[msb-1:0], 1'b0};
        end
      end else begin
        {acc_hi, acc_lo} <= {add_sum, acc_lo[msb:1]};
      end
    end
  end

  // Result held until the next finished operation
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lo       <= '0;
      hi       <= '0;
      neg      <= 1'b0;
      zero     <= 1'b0;
      div_zero <= 1'b0;
    end else if (state_q == alu_pkg::md_fix) begin
      lo       <= fixed[msb:0];
      hi       <= fixed[2*alu_pkg::word_w-1:alu_pkg::word_w];
      // Sign of the quotient or of the full product
      neg      <= div_q ? fixed[msb] : fixed[2*alu_pkg::word_w-1];
      zero     <= (fixed == '0);
      div_zero <= dz_q;
    end
  end

endmodule

`default_nettype wire

/* source/alu64.sv */
`timescale 1ns/1ps
`default_nettype none

module alu64 (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             req,
  input  wire alu_pkg::alu_op_t op,
  input  wire alu_pkg::word_t   r,
  input  wire alu_pkg::word_t   s,
  output logic                  ack,
  output alu_pkg::word_t        y,
  output logic                  c,
  output logic                  n,
  output logic                  z,
  output logic                  v
);

  alu_pkg::ctrl_state_e state_q;
  alu_pkg::alu_op_t     op_q;
  alu_pkg::word_t       r_q;
  alu_pkg::word_t       s_q;
  logic                 start;

  alu_pkg::word_t       lu_y;
  logic                 lu_c, lu_n, lu_v, lu_z;
  logic                 md_done, md_neg, md_zero, md_dz;
  alu_pkg::word_t       md_lo, md_hi;

  logic                 is_iter;
  alu_pkg::word_t       sel_y;
  logic                 sel_c, sel_n, sel_z, sel_v;

  alu_logic_unit u_logic (
    .op (op_q), .r (r_q), .s (s_q),
    .y  (lu_y), .c (lu_c), .n (lu_n), .v (lu_v), .z (lu_z)
  );

  muldiv_unit u_muldiv (
    .clk (clk), .rst_n (rst_n), .start (start), .is_div (op_q == alu_pkg::op_div),
    .r (r_q), .s (s_q), .done (md_done), .lo (md_lo), .hi (md_hi),
    .neg (md_neg), .zero (md_zero), .div_zero (md_dz)
  );

  // MUL and DIV go through the iterative unit, MSW and REM only read its result
  assign is_iter = (op_q == alu_pkg::op_mul) || (op_q == alu_pkg::op_div);

  // ****************************************
  // Result select
  // ****************************************
  always_comb begin
    {sel_y, sel_c, sel_n, sel_z, sel_v} = {lu_y, lu_c, lu_n, lu_z, lu_v};
    case (op_q)
      alu_pkg::op_mul: {sel_y, sel_c, sel_n, sel_z, sel_v} = {md_lo, 1'b0, md_neg, md_zero, 1'b0};
      alu_pkg::op_msw: {sel_y, sel_c, sel_n, sel_z, sel_v} = {md_hi, 1'b0, md_neg, md_zero, 1'b0};
      alu_pkg::op_div, alu_pkg::op_rem: begin
        if (md_dz) begin
          // Divide by zero reports overflow with a zero result
          {sel_y, sel_c, sel_n, sel_z, sel_v} = {alu_pkg::word_t'(0), 4'b0001};
        end else begin
          sel_y = (op_q == alu_pkg::op_div) ? md_lo : md_hi;
          {sel_c, sel_n, sel_z, sel_v} = {1'b0, md_neg, md_zero, 1'b0};
        end
      end
      default: ;
    endcase
  end

  // Operand capture on the accepted request
  always_ff @(posedge clk) begin
    if (state_q == alu_pkg::ctrl_idle && req) {op_q, r_q, s_q} <= {op, r, s};
  end

  // Handshake FSM and output registers
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= alu_pkg::ctrl_idle;
      start   <= 1'b0;
      ack     <= 1'b0;
      {y, c, n, z, v} <= '0;
    end else begin
      start <= 1'b0;
      case (state_q)
        alu_pkg::ctrl_idle: if (req) begin
          state_q <= alu_pkg::ctrl_busy;
          start   <= (op == alu_pkg::op_mul) || (op == alu_pkg::op_div);
        end
        alu_pkg::ctrl_busy: if (!is_iter || md_done) begin
          {y, c, n, z, v} <= {sel_y, sel_c, sel_n, sel_z, sel_v};
          ack     <= 1'b1;
          state_q <= alu_pkg::ctrl_done;
        end
        // Outputs frozen until req drops
        alu_pkg::ctrl_done: if (!req) begin
          ack     <= 1'b0;
          state_q <= alu_pkg::ctrl_idle;
        end
        default: state_q <= alu_pkg::ctrl_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verif/alu64_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module alu64_sva (
  input wire logic           clk,
  input wire logic           rst_n,
  input wire logic           req,
  input wire logic           ack,
  input wire alu_pkg::word_t y
);

  // ack comes out of reset low
  ack_after_reset: assert property (@(posedge clk) !rst_n |=> !ack)
    else $error("ack high in the cycle after reset");

  // A result is only acknowledged for a pending request
  ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n) $rose(ack) |-> $past(req))
    else $error("ack rose without req");

  // Result frozen for as long as ack stays high
  y_stable: assert property (@(posedge clk) disable iff (!rst_n) $past(ack) && ack |-> $stable(y))
    else $error("y changed while ack high");

  // Return to zero only once req has dropped
  ack_fall: assert property (@(posedge clk) disable iff (!rst_n) $fell(ack) |-> !$past(req))
    else $error("ack fell while req still high");

endmodule

bind alu64 alu64_sva sva_checks (.clk(clk), .rst_n(rst_n), .req(req), .ack(ack), .y(y));

`default_nettype wire

/* verif/alu64_ref.svh */
`ifndef ALU64_REF_SVH
`define ALU64_REF_SVH

// Expected results are packed as {y, c, n, z, v}

// True when a 128-bit signed value does not fit a signed word
function automatic logic out_of_range(logic signed [127:0] x);
  logic signed [127:0] max_pos;
  max_pos = {65'b0, {63{1'b1}}};
  return (x > max_pos) || (x < -max_pos - 1);
endfunction

// ****************************************
// Single-cycle opcodes
// ****************************************
function automatic logic [67:0] single_cycle_model(alu_pkg::alu_op_t code,
                                                   alu_pkg::word_t a, alu_pkg::word_t b);
  logic signed [127:0] sa;
  logic signed [127:0] sb;
  logic [127:0]        ua;
  logic [127:0]        ub;
  logic [127:0]        wide;
  alu_pkg::word_t      yy;
  logic                cc;
  logic                vv;
  // Sign and zero extension to 128 bits
  sa = {{64{a[63]}}, a};
  sb = {{64{b[63]}}, b};
  ua = {64'b0, a};
  ub = {64'b0, b};
  cc = 1'b0;
  vv = 1'b0;
  // Unknown and spare codes pass S
  yy = b;
  case (code)
    alu_pkg::op_inc: begin
      wide = ub + 1;
      yy = wide[63:0];
      cc = wide[64];
      vv = out_of_range(sb + 1);
    end
    alu_pkg::op_dec: begin
      // Bit 64 of the wide difference is the borrow
      wide = ub - 1;
      yy = wide[63:0];
      cc = wide[64];
      vv = out_of_range(sb - 1);
    end
    alu_pkg::op_add: begin
      wide = ua + ub;
      yy = wide[63:0];
      cc = wide[64];
      vv = out_of_range(sa + sb);
    end
    alu_pkg::op_sub: begin
      wide = ua - ub;
      yy = wide[63:0];
      cc = wide[64];
      vv = out_of_range(sa - sb);
    end
    alu_pkg::op_neg: begin
      wide = -sb;
      yy = wide[63:0];
      vv = out_of_range(-sb);
    end
    alu_pkg::op_and:    yy = a & b;
    alu_pkg::op_or:     yy = a | b;
    alu_pkg::op_xor:    yy = a ^ b;
    alu_pkg::op_not:    yy = ~b;
    alu_pkg::op_nand:   yy = ~(a & b);
    alu_pkg::op_nor:    yy = ~(a | b);
    alu_pkg::op_xnor:   yy = ~(a ^ b);
    alu_pkg::op_zeros:  yy = '0;
    alu_pkg::op_ones:   yy = '1;
    alu_pkg::op_pass_r: yy = a;
    alu_pkg::op_lshl: begin
      wide = ub << 1;
      yy = wide[63:0];
      cc = wide[64];
    end
    alu_pkg::op_lshr: begin
      yy = b >> 1;
      cc = b[0];
    end
    alu_pkg::op_ashl: begin
      // Sign stays put, bit 62 falls out of the magnitude
      wide = ub << 1;
      yy = {b[63], wide[62:0]};
      cc = b[62];
      vv = out_of_range(sb * 2);
    end
    alu_pkg::op_ashr: begin
      wide = sb >>> 1;
      yy = wide[63:0];
      cc = b[0];
    end
    alu_pkg::op_ror: begin
      wide = {b, b} >> 1;
      yy = wide[63:0];
      cc = b[0];
    end
    alu_pkg::op_rol: begin
      wide = {b, b} << 1;
      yy = wide[127:64];
      cc = b[63];
    end
    default: yy = b;
  endcase
  return {yy, cc, yy[63], yy == '0, vv};
endfunction

// ****************************************
// MUL, MSW, DIV and REM
// ****************************************
function automatic logic [67:0] muldiv_model(alu_pkg::alu_op_t code,
                                             alu_pkg::word_t a, alu_pkg::word_t b);
  logic signed [127:0] sa;
  logic signed [127:0] sb;
  logic signed [127:0] prod;
  logic signed [127:0] quo;
  logic signed [127:0] rem;
  sa = {{64{a[63]}}, a};
  sb = {{64{b[63]}}, b};
  if (code == alu_pkg::op_mul || code == alu_pkg::op_msw) begin
    prod = sa * sb;
    if (code == alu_pkg::op_mul) begin
      return {prod[63:0], 1'b0, prod[127], prod == 0, 1'b0};
    end
    return {prod[127:64], 1'b0, prod[127], prod == 0, 1'b0};
  end
  // Divide by zero reports overflow with a zero result
  if (b == '0) begin
    return {64'h0, 4'b0001};
  end
  // Quotient truncates toward zero, remainder is a magnitude
  quo = sa / sb;
  rem = (sa < 0 ? -sa : sa) % (sb < 0 ? -sb : sb);
  if (code == alu_pkg::op_div) begin
    return {quo[63:0], 1'b0, quo[63], (quo[63:0] == 0) && (rem == 0), 1'b0};
  end
  return {rem[63:0], 1'b0, quo[63], (quo[63:0] == 0) && (rem == 0), 1'b0};
endfunction

`endif

/* verif/alu64_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module alu64_tb;

  localparam int          clk_period = 8;
  localparam int unsigned rand_seed  = 32'h7252_3f0f;
  // Upper bound on transactions, each allowed 80 cycles
  localparam int          op_budget  = 280;
  localparam longint      timeout_ns = longint'(op_budget) * 80 * clk_period + 10 * clk_period;
  // Cycles one handshake phase may take
  localparam int          ack_limit  = 100;

  logic             clk = 1'b0;
  logic             rst_n;
  logic             req;
  alu_pkg::alu_op_t op;
  alu_pkg::word_t   r;
  alu_pkg::word_t   s;
  logic             ack;
  alu_pkg::word_t   y;
  logic             c;
  logic             n;
  logic             z;
  logic             v;

  int               checks = 0;
  int               errors = 0;
  int unsigned      seed_dummy;

  alu64 UUT (
    .clk (clk), .rst_n (rst_n), .req (req), .op (op), .r (r), .s (s),
    .ack (ack), .y (y), .c (c), .n (n), .z (z), .v (v)
  );

  `include "alu64_ref.svh"

  always #(clk_period / 2) clk = ~clk;

  // ****************************************
  // Helpers
  // ****************************************

  task automatic check(input string name, input logic [63:0] act, input logic [63:0] exp);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR: %s actual %h expected %h", name, act, exp);
    end
  endtask

  // Result word plus all four flags
  task automatic check_result(input alu_pkg::alu_op_t code, input logic [67:0] act,
                              input logic [67:0] exp);
    check($sformatf("y (op %0d)", code), act[67:4], exp[67:4]);
    check($sformatf("c (op %0d)", code), 64'(act[3]), 64'(exp[3]));
    check($sformatf("n (op %0d)", code), 64'(act[2]), 64'(exp[2]));
    check($sformatf("z (op %0d)", code), 64'(act[1]), 64'(exp[1]));
    check($sformatf("v (op %0d)", code), 64'(act[0]), 64'(exp[0]));
  endtask

  function automatic alu_pkg::word_t rand_word();
    return {$urandom, $urandom};
  endfunction

  // Sample ack after each edge until it reaches the wanted level
  task automatic wait_ack(input logic level);
    int cycles;
    cycles = 0;
    while (ack !== level && cycles < ack_limit) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (ack !== level) begin
      errors++;
      $display("Handshake failure: ack did not go to %0d within %0d cycles", level, ack_limit);
    end
  endtask

  // One four-phase transaction, req optionally held for extra cycles after ack
  task automatic do_op(input alu_pkg::alu_op_t code, input alu_pkg::word_t a,
                       input alu_pkg::word_t b, input int hold, output logic [67:0] res);
    @(posedge clk);
    #1;
    op  = code;
    r   = a;
    s   = b;
    req = 1'b1;
    wait_ack(1'b1);
    res = {y, c, n, z, v};
    repeat (hold) begin
      @(posedge clk);
      #1;
      check("y held", y, res[67:4]);
      check("flags held", 64'({c, n, z, v}), 64'(res[3:0]));
      check("ack held", 64'(ack), 64'd1);
    end
    req = 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic single_op(input alu_pkg::alu_op_t code, input alu_pkg::word_t a,
                           input alu_pkg::word_t b);
    logic [67:0] act;
    do_op(code, a, b, 0, act);
    check_result(code, act, single_cycle_model(code, a, b));
  endtask

  // MUL then MSW, or DIV then REM
  task automatic muldiv_pair(input alu_pkg::alu_op_t code, input alu_pkg::word_t a,
                             input alu_pkg::word_t b);
    logic [67:0]      act;
    alu_pkg::alu_op_t second;
    second = (code == alu_pkg::op_mul) ? alu_pkg::op_msw : alu_pkg::op_rem;
    do_op(code, a, b, 0, act);
    check_result(code, act, muldiv_model(code, a, b));
    // Fresh operands, the high word must come from the stored result
    do_op(second, rand_word(), rand_word(), 0, act);
    check_result(second, act, muldiv_model(second, a, b));
  endtask

  function automatic alu_pkg::word_t corner(int idx);
    case (idx)
      0: return 64'h0;
      1: return 64'h7FFF_FFFF_FFFF_FFFF;
      2: return 64'h8000_0000_0000_0000;
      3: return '1;
      default: return 64'h1;
    endcase
  endfunction

  // ****************************************
  // Directed tests
  // ****************************************

  task automatic arith_tests();
    alu_pkg::alu_op_t codes [5] = '{alu_pkg::op_inc, alu_pkg::op_dec, alu_pkg::op_add,
                                    alu_pkg::op_sub, alu_pkg::op_neg};
    for (int i = 0; i < 5; i++) begin
      single_op(alu_pkg::op_inc, rand_word(), corner(i));
      single_op(alu_pkg::op_dec, rand_word(), corner(i));
      single_op(alu_pkg::op_neg, rand_word(), corner(i));
      for (int j = 0; j < 5; j++) begin
        single_op(alu_pkg::op_add, corner(i), corner(j));
        single_op(alu_pkg::op_sub, corner(i), corner(j));
      end
    end
    repeat (8) begin
      foreach (codes[m]) single_op(codes[m], rand_word(), rand_word());
    end
  endtask

  // Logic, constants and the spare codes 26 to 31
  task automatic logic_tests();
    alu_pkg::alu_op_t codes [17] = '{alu_pkg::op_and, alu_pkg::op_or, alu_pkg::op_xor,
                                     alu_pkg::op_not, alu_pkg::op_nand, alu_pkg::op_nor,
                                     alu_pkg::op_xnor, alu_pkg::op_zeros, alu_pkg::op_ones,
                                     alu_pkg::op_pass_r, alu_pkg::op_pass_s, 5'd26, 5'd27,
                                     5'd28, 5'd29, 5'd30, 5'd31};
    repeat (4) begin
      foreach (codes[m]) single_op(codes[m], rand_word(), rand_word());
    end
  endtask

  task automatic shift_tests();
    alu_pkg::alu_op_t codes [6] = '{alu_pkg::op_lshl, alu_pkg::op_lshr, alu_pkg::op_ashl,
                                    alu_pkg::op_ashr, alu_pkg::op_ror, alu_pkg::op_rol};
    int               pos [4] = '{0, 1, 62, 63};
    alu_pkg::word_t   b;
    for (int k = 0; k < 8; k++) begin
      // Single-bit operands first, then random ones
      b = (k < 4) ? (64'h1 << pos[k]) : rand_word();
      foreach (codes[m]) single_op(codes[m], rand_word(), b);
    end
  endtask

  task automatic mul_tests();
    muldiv_pair(alu_pkg::op_mul, 64'h0, rand_word());
    muldiv_pair(alu_pkg::op_mul, '1, '1);
    muldiv_pair(alu_pkg::op_mul, 64'h8000_0000_0000_0000, '1);
    muldiv_pair(alu_pkg::op_mul, 64'h7FFF_FFFF_FFFF_FFFF, 64'h7FFF_FFFF_FFFF_FFFF);
    repeat (6) muldiv_pair(alu_pkg::op_mul, rand_word(), rand_word());
  endtask

  task automatic div_tests();
    alu_pkg::word_t b;
    muldiv_pair(alu_pkg::op_div, 64'h0, 64'd7);
    muldiv_pair(alu_pkg::op_div, 64'hFFFF_FFFF_FFFF_FFF9, 64'd2);
    muldiv_pair(alu_pkg::op_div, 64'h8000_0000_0000_0000, '1);
    muldiv_pair(alu_pkg::op_div, 64'd5, 64'hFFFF_FFFF_FFFF_FFF7);
    repeat (6) begin
      // Divisor of varied magnitude and sign, never zero
      b = rand_word() >> $urandom_range(0, 62);
      if (b == '0) b = 64'd1;
      if ($urandom_range(0, 1) == 1) b = -b;
      muldiv_pair(alu_pkg::op_div, rand_word(), b);
    end
    muldiv_pair(alu_pkg::op_div, rand_word(), 64'h0);
    muldiv_pair(alu_pkg::op_div, 64'h0, 64'h0);
  endtask

  // req held past ack, then a request right after ack falls
  task automatic handshake_tests();
    logic [67:0]    act;
    alu_pkg::word_t a;
    alu_pkg::word_t b;
    a = rand_word();
    b = rand_word();
    do_op(alu_pkg::op_add, a, b, 3, act);
    check_result(alu_pkg::op_add, act, single_cycle_model(alu_pkg::op_add, a, b));
    do_op(alu_pkg::op_mul, a, b, 2, act);
    check_result(alu_pkg::op_mul, act, muldiv_model(alu_pkg::op_mul, a, b));
    single_op(alu_pkg::op_inc, a, b);
  endtask

  // Watchdog sized from the transaction budget
  initial begin
    #(timeout_ns);
    $display("Timeout: the run did not finish within %0d ns", timeout_ns);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    // Seed the generator once for a repeatable run
    seed_dummy = $urandom(rand_seed);
    rst_n = 1'b0;
    req   = 1'b0;
    op    = '0;
    r     = '0;
    s     = '0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    arith_tests();
    logic_tests();
    shift_tests();
    mul_tests();
    div_tests();
    handshake_tests();
    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+verif
common/alu_pkg.sv
source/alu_logic_unit.sv
muldiv/muldiv_unit.sv
source/alu64.sv
verif/alu64_sva.sv
verif/alu64_tb.sv

/* Makefile */
# Verilator build and run of the alu64 testbench

VERILATOR ?= verilator
TOP       ?= alu64_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST)) verif/alu64_ref.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

check:
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
